//--- rv32_isa_pkg.sv
package rv32_isa_pkg;

    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;
    localparam int OPCODE_WIDTH   = 7;
    localparam int FUNCT3_WIDTH   = 3;
    localparam int FUNCT7_WIDTH   = 7;

    typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [OPCODE_WIDTH-1:0]   opcode_t;
    typedef logic [FUNCT3_WIDTH-1:0]   funct3_t;
    typedef logic [FUNCT7_WIDTH-1:0]   funct7_t;

    // major opcodes of the supported subset.
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // alu funct3, shared by OP and OP-IMM.
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SRL  = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch funct3.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // selects SUB and SRA/SRAI.
    localparam funct7_t F7_ALT  = 7'b0100000;

    typedef struct packed {
        funct7_t   funct7;
        reg_addr_t rs2;
        reg_addr_t rs1;
        funct3_t   funct3;
        reg_addr_t rd;
        opcode_t   op;
    } instruction_s;

endpackage

//--- exec_pkg.sv
package exec_pkg;

    // word address, so the two low byte bits are dropped.
    localparam int PC_WIDTH = 22;

    typedef logic [PC_WIDTH-1:0] pc_t;

    typedef struct packed {
        logic                        valid;
        rv32_isa_pkg::instruction_s  instr;
        rv32_isa_pkg::reg_data_t     rs1_val;
        rv32_isa_pkg::reg_data_t     rs2_val;
        rv32_isa_pkg::reg_data_t     pc_plus4;
        logic                        rd_we;
    } issue_s;

    typedef struct packed {
        logic                        we;
        rv32_isa_pkg::reg_addr_t     rd;
        rv32_isa_pkg::reg_data_t     data;
    } wb_s;

    typedef struct packed {
        logic                        valid;
        rv32_isa_pkg::reg_addr_t     rd;
        logic                        we;
        rv32_isa_pkg::reg_data_t     data;
        pc_t                         jalr_addr;
        logic                        jump_now;
    } result_s;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv32_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv32_isa_pkg::reg_addr_t rs2_addr_i,
    input  exec_pkg::wb_s           wb_i,
    output rv32_isa_pkg::reg_data_t rs1_data_o,
    output rv32_isa_pkg::reg_data_t rs2_data_o
);

    rv32_isa_pkg::reg_data_t regs [rv32_isa_pkg::NUM_REGS];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < rv32_isa_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_i.we && (wb_i.rd != '0))
        begin
            // x0 is never written, so it keeps its reset value.
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32_isa_pkg::reg_data_t    rs1_i,
    input  rv32_isa_pkg::reg_data_t    rs2_i,
    input  rv32_isa_pkg::reg_data_t    pc_plus4_i,
    input  rv32_isa_pkg::instruction_s op_i,
    output rv32_isa_pkg::reg_data_t    result_o,
    output exec_pkg::pc_t              jalr_addr_o,
    output logic                       jump_now_o
);

    logic                    is_alu_op;
    logic                    is_imm_op;
    logic                    sub_not_add;
    logic                    sign_fill;
    logic                    slt;
    logic                    sltu;
    logic [4:0]              sh_amount;
    logic [32:0]             sum;
    logic [32:0]             shr_out;
    rv32_isa_pkg::reg_data_t i_imm;
    rv32_isa_pkg::reg_data_t u_imm;
    rv32_isa_pkg::reg_data_t op2;
    rv32_isa_pkg::reg_data_t adder_in;
    rv32_isa_pkg::reg_data_t shl_out;
    rv32_isa_pkg::reg_data_t xor_out;
    rv32_isa_pkg::reg_data_t and_out;
    rv32_isa_pkg::reg_data_t or_out;
    logic                    rs1_eq_rs2;
    logic                    rs1_lt_rs2;
    logic                    rs1_ltu_rs2;

    assign is_alu_op = (op_i.op == rv32_isa_pkg::OPC_OP)
                    || (op_i.op == rv32_isa_pkg::OPC_OP_IMM);
    assign is_imm_op = (op_i.op == rv32_isa_pkg::OPC_OP_IMM)
                    || (op_i.op == rv32_isa_pkg::OPC_JALR);

    assign i_imm = {{20{op_i.funct7[6]}}, op_i.funct7, op_i.rs2};
    assign u_imm = {op_i.funct7, op_i.rs2, op_i.rs1, op_i.funct3, 12'b0};

    assign op2 = is_imm_op ? i_imm : rs2_i;

    // compares subtract too, so the adder is shared.
    assign sub_not_add = is_alu_op
        && ((op_i.funct3 == rv32_isa_pkg::F3_SLT)
         || (op_i.funct3 == rv32_isa_pkg::F3_SLTU)
         || ((op_i.op == rv32_isa_pkg::OPC_OP)
          && (op_i.funct3 == rv32_isa_pkg::F3_ADD)
          && (op_i.funct7 == rv32_isa_pkg::F7_ALT)));

    assign adder_in = sub_not_add ? ~op2 : op2;
    assign sum      = {rs1_i[31], rs1_i} + {adder_in[31], adder_in} + {32'd0, sub_not_add};

    // 33 bit signed difference cannot overflow.
    assign slt  = sum[32];
    // unsigned order flips when the sign bits differ.
    assign sltu = sum[32] ^ rs1_i[31] ^ op2[31];

    assign sh_amount = is_imm_op ? op_i.rs2 : rs2_i[4:0];
    assign sign_fill = rs1_i[31] && (op_i.funct7 == rv32_isa_pkg::F7_ALT);
    assign shr_out   = $signed({sign_fill, rs1_i}) >>> sh_amount;
    assign shl_out   = rs1_i << sh_amount;
    assign xor_out   = rs1_i ^ op2;
    assign and_out   = rs1_i & op2;
    assign or_out    = rs1_i | op2;

    always_comb
    begin
        result_o    = '0;
        jalr_addr_o = '0;
        case (op_i.op)
            rv32_isa_pkg::OPC_LUI:
                result_o = u_imm;
            rv32_isa_pkg::OPC_AUIPC:
                result_o = u_imm + pc_plus4_i - 32'd4;
            rv32_isa_pkg::OPC_OP_IMM,
            rv32_isa_pkg::OPC_OP:
            begin
                case (op_i.funct3)
                    rv32_isa_pkg::F3_ADD:  result_o = sum[31:0];
                    rv32_isa_pkg::F3_SLL:  result_o = shl_out;
                    rv32_isa_pkg::F3_SLT:  result_o = {31'd0, slt};
                    rv32_isa_pkg::F3_SLTU: result_o = {31'd0, sltu};
                    rv32_isa_pkg::F3_XOR:  result_o = xor_out;
                    rv32_isa_pkg::F3_SRL:  result_o = shr_out[31:0];
                    rv32_isa_pkg::F3_OR:   result_o = or_out;
                    rv32_isa_pkg::F3_AND:  result_o = and_out;
                endcase
            end
            rv32_isa_pkg::OPC_JALR:
            begin
                result_o    = pc_plus4_i;
                jalr_addr_o = sum[2 +: exec_pkg::PC_WIDTH];
            end
            rv32_isa_pkg::OPC_JAL:
                result_o = pc_plus4_i;
            default:
                result_o = '0;
        endcase
    end

    assign rs1_eq_rs2  = (rs1_i == rs2_i);
    assign rs1_lt_rs2  = ($signed(rs1_i) < $signed(rs2_i));
    assign rs1_ltu_rs2 = (rs1_i < rs2_i);

    always_comb
    begin
        jump_now_o = 1'b0;
        if (op_i.op == rv32_isa_pkg::OPC_BRANCH)
        begin
            case (op_i.funct3)
                rv32_isa_pkg::F3_BEQ:  jump_now_o = rs1_eq_rs2;
                rv32_isa_pkg::F3_BNE:  jump_now_o = ~rs1_eq_rs2;
                rv32_isa_pkg::F3_BLT:  jump_now_o = rs1_lt_rs2;
                rv32_isa_pkg::F3_BGE:  jump_now_o = ~rs1_lt_rs2;
                rv32_isa_pkg::F3_BLTU: jump_now_o = rs1_ltu_rs2;
                rv32_isa_pkg::F3_BGEU: jump_now_o = ~rs1_ltu_rs2;
                default:               jump_now_o = 1'b0;
            endcase
        end
    end

endmodule

//--- decode_issue.sv
`timescale 1ns/1ps

module decode_issue (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       instr_valid_i,
    input  rv32_isa_pkg::instruction_s instr_i,
    input  rv32_isa_pkg::reg_data_t    pc_i,
    input  exec_pkg::wb_s              wb_i,
    output exec_pkg::issue_s           issue_o
);

    rv32_isa_pkg::reg_data_t rs1_data;
    rv32_isa_pkg::reg_data_t rs2_data;
    logic                    writes_rd;

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rs1_addr_i (instr_i.rs1),
        .rs2_addr_i (instr_i.rs2),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // opcodes that produce a register result.
    always_comb
    begin
        case (instr_i.op)
            rv32_isa_pkg::OPC_LUI,
            rv32_isa_pkg::OPC_AUIPC,
            rv32_isa_pkg::OPC_OP_IMM,
            rv32_isa_pkg::OPC_OP,
            rv32_isa_pkg::OPC_JAL,
            rv32_isa_pkg::OPC_JALR:
                writes_rd = 1'b1;
            default:
                writes_rd = 1'b0;
        endcase
    end

    always_comb
    begin
        issue_o.valid    = instr_valid_i;
        issue_o.instr    = instr_i;
        issue_o.rs1_val  = rs1_data;
        issue_o.rs2_val  = rs2_data;
        issue_o.pc_plus4 = pc_i + 32'd4;
        // writes to x0 are dropped here already.
        issue_o.rd_we    = writes_rd && (instr_i.rd != '0);
    end

endmodule

//--- exec_stage_reg.sv
`timescale 1ns/1ps

module exec_stage_reg (
    input  logic             clk_i,
    input  logic             rst_i,
    input  exec_pkg::issue_s issue_i,
    input  exec_pkg::wb_s    wb_i,
    output exec_pkg::issue_s ex_o
);

    logic                    wb_active;
    logic                    fwd_rs1;
    logic                    fwd_rs2;
    rv32_isa_pkg::reg_data_t rs1_val;
    rv32_isa_pkg::reg_data_t rs2_val;

    // the register file is written on this same edge, so decode read the old value.
    assign wb_active = wb_i.we && (wb_i.rd != '0);
    assign fwd_rs1   = wb_active && (wb_i.rd == issue_i.instr.rs1);
    assign fwd_rs2   = wb_active && (wb_i.rd == issue_i.instr.rs2);

    assign rs1_val   = fwd_rs1 ? wb_i.data : issue_i.rs1_val;
    assign rs2_val   = fwd_rs2 ? wb_i.data : issue_i.rs2_val;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ex_o.valid <= 1'b0;
        end
        else
        begin
            ex_o.valid <= issue_i.valid;
        end
        ex_o.instr    <= issue_i.instr;
        ex_o.rs1_val  <= rs1_val;
        ex_o.rs2_val  <= rs2_val;
        ex_o.pc_plus4 <= issue_i.pc_plus4;
        ex_o.rd_we    <= issue_i.rd_we;
    end

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic              clk_i,
    input  logic              rst_i,
    input  exec_pkg::issue_s  ex_i,
    output exec_pkg::wb_s     wb_o,
    output exec_pkg::result_s result_o
);

    rv32_isa_pkg::reg_data_t alu_result;
    exec_pkg::pc_t           alu_jalr_addr;
    logic                    alu_jump;

    alu i_alu (
        .rs1_i       (ex_i.rs1_val),
        .rs2_i       (ex_i.rs2_val),
        .pc_plus4_i  (ex_i.pc_plus4),
        .op_i        (ex_i.instr),
        .result_o    (alu_result),
        .jalr_addr_o (alu_jalr_addr),
        .jump_now_o  (alu_jump)
    );

    // register write lands at the next edge, together with the result register.
    always_comb
    begin
        wb_o.we   = ex_i.valid && ex_i.rd_we;
        wb_o.rd   = ex_i.instr.rd;
        wb_o.data = alu_result;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            result_o.valid <= 1'b0;
            result_o.we    <= 1'b0;
        end
        else
        begin
            result_o.valid <= ex_i.valid;
            result_o.we    <= wb_o.we;
        end
        result_o.rd        <= ex_i.instr.rd;
        result_o.data      <= alu_result;
        result_o.jalr_addr <= alu_jalr_addr;
        result_o.jump_now  <= ex_i.valid && alu_jump;
    end

endmodule

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       instr_valid_i,
    input  rv32_isa_pkg::instruction_s instr_i,
    input  rv32_isa_pkg::reg_data_t    pc_i,
    output exec_pkg::result_s          result_o
);

    exec_pkg::issue_s issue;
    exec_pkg::issue_s ex;
    exec_pkg::wb_s    wb;

    decode_issue i_decode_issue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .wb_i          (wb),
        .issue_o       (issue)
    );

    // wb also feeds the stage register for the one-behind bypass.
    exec_stage_reg i_exec_stage_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .issue_i (issue),
        .wb_i    (wb),
        .ex_o    (ex)
    );

    exec_unit i_exec_unit (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .ex_i     (ex),
        .wb_o     (wb),
        .result_o (result_o)
    );

endmodule

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

    localparam int HALF_PERIOD_NS = 20;
    localparam int RESET_CYCLES   = 2;
    localparam int NUM_SLOTS      = 2000;
    localparam int WATCHDOG_NS    = (NUM_SLOTS + 10) * 2 * HALF_PERIOD_NS;

    typedef struct packed {
        exec_pkg::result_s res;
        logic              is_jalr;
        int                due_tick;
    } expect_s;

    logic                       clk_i;
    logic                       rst_i;
    logic                       instr_valid_i;
    rv32_isa_pkg::instruction_s instr_i;
    rv32_isa_pkg::reg_data_t    pc_i;
    exec_pkg::result_s          result_o;

    int                         seed;
    int                         tick;
    rv32_isa_pkg::reg_data_t    model_regs [32];
    expect_s                    exp_q [$];

    exec_core i_exec_core (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .result_o      (result_o)
    );

    initial
    begin
        clk_i = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk_i = ~clk_i;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            fail_run($sformatf("ERROR: %s expected 0x%08h actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    // register result of one instruction by RV32I rules.
    function automatic rv32_isa_pkg::reg_data_t expected_data(input logic [31:0] w,
        input rv32_isa_pkg::reg_data_t a, input rv32_isa_pkg::reg_data_t b,
        input rv32_isa_pkg::reg_data_t pc);
        rv32_isa_pkg::reg_data_t imm_i;
        rv32_isa_pkg::reg_data_t op2;
        logic [4:0]              shamt;
        logic                    alt;
        imm_i = {{20{w[31]}}, w[31:20]};
        alt   = (w[31:25] == 7'b0100000);
        op2   = (w[6:0] == rv32_isa_pkg::OPC_OP) ? b : imm_i;
        shamt = op2[4:0];
        if (w[6:0] == rv32_isa_pkg::OPC_LUI)
            return {w[31:12], 12'd0};
        if (w[6:0] == rv32_isa_pkg::OPC_AUIPC)
            return {w[31:12], 12'd0} + pc;
        if ((w[6:0] == rv32_isa_pkg::OPC_JAL) || (w[6:0] == rv32_isa_pkg::OPC_JALR))
            return pc + 32'd4;
        if ((w[6:0] != rv32_isa_pkg::OPC_OP) && (w[6:0] != rv32_isa_pkg::OPC_OP_IMM))
            return '0;
        case (w[14:12])
            3'b000:
            begin
                if ((w[6:0] == rv32_isa_pkg::OPC_OP) && alt)
                    return a - op2;
                return a + op2;
            end
            3'b001: return a << shamt;
            3'b010: return ($signed(a) < $signed(op2)) ? 32'd1 : 32'd0;
            3'b011: return (a < op2) ? 32'd1 : 32'd0;
            3'b100: return a ^ op2;
            3'b101:
            begin
                if (alt)
                    return $signed(a) >>> shamt;
                return a >> shamt;
            end
            3'b110: return a | op2;
            default: return a & op2;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3,
        input rv32_isa_pkg::reg_data_t a, input rv32_isa_pkg::reg_data_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // random instruction, registers limited to x0..x7 so dependencies are common.
    task automatic make_instr(output logic [31:0] w);
        logic [31:0] r;
        logic [31:0] k;
        r = $random(seed);
        k = $random(seed);
        w = r;
        w[11:7]  = {2'b00, k[2:0]};
        w[19:15] = {2'b00, k[5:3]};
        if (k[11:8] == 4'd0)
        begin
            case (k[13:12])
                2'd0: w[6:0] = 7'b0000011;
                2'd1: w[6:0] = 7'b0100011;
                2'd2: w[6:0] = 7'b0001111;
                default: w[6:0] = 7'b1110011;
            endcase
            return;
        end
        case (k[16:14])
            3'd0: w[6:0] = rv32_isa_pkg::OPC_LUI;
            3'd1: w[6:0] = rv32_isa_pkg::OPC_AUIPC;
            3'd2: w[6:0] = rv32_isa_pkg::OPC_OP;
            3'd3: w[6:0] = rv32_isa_pkg::OPC_JAL;
            3'd4: w[6:0] = rv32_isa_pkg::OPC_JALR;
            3'd5: w[6:0] = rv32_isa_pkg::OPC_BRANCH;
            default: w[6:0] = rv32_isa_pkg::OPC_OP_IMM;
        endcase
        if ((w[6:0] == rv32_isa_pkg::OPC_OP) || (w[6:0] == rv32_isa_pkg::OPC_BRANCH))
            w[24:20] = {2'b00, k[19:17]};
        // the alternate funct7 picks SUB and SRA.
        if (w[6:0] == rv32_isa_pkg::OPC_OP)
            w[31:25] = (((w[14:12] == 3'b000) || (w[14:12] == 3'b101)) && k[20])
                     ? 7'b0100000 : 7'b0000000;
        if (w[6:0] == rv32_isa_pkg::OPC_JALR)
            w[14:12] = 3'b000;
        // funct3 010 and 011 are no branch, so move them to BLTU and BGEU.
        if ((w[6:0] == rv32_isa_pkg::OPC_BRANCH) && (w[14:13] == 2'b01))
            w[14] = 1'b1;
        if ((w[6:0] == rv32_isa_pkg::OPC_OP_IMM) && (w[13:12] == 2'b01))
        begin
            w[31:25] = (w[14] && k[20]) ? 7'b0100000 : 7'b0000000;
            if (k[23:21] == 3'd0)
                w[24:20] = k[24] ? 5'd31 : 5'd0;
        end
    endtask

    // model step in program order, queues what the DUT must show later.
    task automatic issue_instr(input logic [31:0] w, input rv32_isa_pkg::reg_data_t pc);
        expect_s                 e;
        rv32_isa_pkg::reg_data_t a;
        rv32_isa_pkg::reg_data_t b;
        rv32_isa_pkg::reg_data_t tgt;
        logic                    writes;
        a      = model_regs[w[19:15]];
        b      = model_regs[w[24:20]];
        tgt    = a + {{20{w[31]}}, w[31:20]};
        writes = (w[11:7] != 5'd0)
              && ((w[6:0] == rv32_isa_pkg::OPC_LUI) || (w[6:0] == rv32_isa_pkg::OPC_AUIPC)
               || (w[6:0] == rv32_isa_pkg::OPC_OP_IMM) || (w[6:0] == rv32_isa_pkg::OPC_OP)
               || (w[6:0] == rv32_isa_pkg::OPC_JAL) || (w[6:0] == rv32_isa_pkg::OPC_JALR));
        e               = '0;
        e.res.valid     = 1'b1;
        e.res.rd        = w[11:7];
        e.res.we        = writes;
        e.res.data      = expected_data(w, a, b, pc);
        e.res.jalr_addr = tgt[2 +: exec_pkg::PC_WIDTH];
        e.res.jump_now  = (w[6:0] == rv32_isa_pkg::OPC_BRANCH) && branch_taken(w[14:12], a, b);
        e.is_jalr       = (w[6:0] == rv32_isa_pkg::OPC_JALR);
        e.due_tick      = tick + 2;
        if (writes)
            model_regs[w[11:7]] = e.res.data;
        exp_q.push_back(e);
    endtask

    task automatic check_outputs();
        expect_s           e;
        exec_pkg::result_s act;
        act = result_o;
        if (act.valid !== 1'b0)
        begin
            if (exp_q.size() == 0)
            begin
                fail_run($sformatf("result valid at cycle %0d with nothing outstanding", tick));
            end
            else
            begin
                e = exp_q.pop_front();
                if (e.due_tick != tick)
                    fail_run($sformatf("result came at cycle %0d, was due at cycle %0d",
                                       tick, e.due_tick));
                check_value("result_o.rd", {27'd0, e.res.rd}, {27'd0, act.rd});
                check_value("result_o.we", {31'd0, e.res.we}, {31'd0, act.we});
                check_value("result_o.data", e.res.data, act.data);
                if (e.is_jalr)
                    check_value("result_o.jalr_addr", {10'd0, e.res.jalr_addr},
                                {10'd0, act.jalr_addr});
                check_value("result_o.jump_now", {31'd0, e.res.jump_now},
                            {31'd0, act.jump_now});
            end
        end
        else if ((exp_q.size() != 0) && (exp_q[0].due_tick <= tick))
        begin
            fail_run($sformatf("no result at cycle %0d, one was due", tick));
        end
    endtask

    // outputs are stable at the falling edge, where the next inputs go in too.
    task automatic advance();
        @(negedge clk_i);
        tick = tick + 1;
        check_outputs();
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        fail_run("timeout, the run took longer than the stimulus allows");
    end

    initial
    begin
        logic [31:0]             w;
        logic [31:0]             r;
        rv32_isa_pkg::reg_data_t pc;
        seed          = 47;
        tick          = 0;
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) advance();
        rst_i = 1'b0;
        for (int s = 0; s < NUM_SLOTS; s++)
        begin
            r = $random(seed);
            if (r[1:0] != 2'b00)
            begin
                make_instr(w);
                pc            = $random(seed);
                pc[1:0]       = 2'b00;
                instr_valid_i = 1'b1;
                instr_i       = w;
                pc_i          = pc;
                issue_instr(w, pc);
            end
            else
            begin
                // bubble with a junk word that must not write anything.
                instr_valid_i = 1'b0;
                instr_i       = $random(seed);
            end
            advance();
        end
        instr_valid_i = 1'b0;
        repeat (3) advance();
        if (exp_q.size() != 0)
        begin
            fail_run($sformatf("%0d results never came out", exp_q.size()));
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- sim.f
rv32_isa_pkg.sv
exec_pkg.sv
reg_file.sv
alu.sv
decode_issue.sv
exec_stage_reg.sv
exec_unit.sv
exec_core.sv
tb_exec_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the exec_core testbench with verilator and runs it.
# the exit status is the simulator's own, nonzero when the run fails.
cd "$(dirname "$0")" \
    && verilator --binary --timing --top-module tb_exec_core \
        -f sim.f -o tb_exec_core \
    && ./obj_dir/tb_exec_core \
    || exit 1
